/* verilog/icache_cfg_pkg.sv */
// Address layout and default geometry of the instruction cache, referenced by scoped name
package icache_cfg_pkg;

    // Byte address width seen by the CPU
    localparam int ADDR_WIDTH = 32;

    // Byte offset bits inside one 32-byte line
    localparam int BLOCK_WIDTH = 5;

    // One instruction word
    localparam int WORD_WIDTH = 32;

    // Full line as delivered by the refill port
    localparam int LINE_WIDTH = 256;

    // Picks one of eight words in a line, sits just above the byte-in-word bits
    localparam int WORD_SEL_WIDTH = 3;

    // Line address, also stored as the tag of each way
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - BLOCK_WIDTH;

    // 64 sets unless the top level says otherwise
    localparam int DEFAULT_SET_WIDTH = 6;

endpackage

/* verilog/icache_types_pkg.sv */
// Packed structs for CPU, refill and invalidate traffic and for the tag RAM entry
package icache_types_pkg;

    // One cache line of data
    typedef logic [icache_cfg_pkg::LINE_WIDTH-1:0] line_t;

    // CPU fetch request, one-cycle strobe
    typedef struct packed {
        logic                                valid;
        logic [icache_cfg_pkg::ADDR_WIDTH-1:0] addr;
    } cpu_req_t;

    // Fetch response, ack high for one cycle
    typedef struct packed {
        logic                                ack;
        logic [icache_cfg_pkg::WORD_WIDTH-1:0] word;
    } cpu_resp_t;

    // Line fill request to the next memory level
    typedef struct packed {
        logic                                     valid;
        logic [icache_cfg_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
    } refill_req_t;

    // Line data back from memory
    typedef struct packed {
        logic  valid;
        line_t line;
    } refill_t;

    // Set invalidate, only the set field of addr matters
    typedef struct packed {
        logic                                valid;
        logic [icache_cfg_pkg::ADDR_WIDTH-1:0] addr;
    } inval_t;

    // Per-way tag, the full line address plus valid
    typedef struct packed {
        logic                                     valid;
        logic [icache_cfg_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
    } way_tag_t;

    // lru names the way to replace next
    typedef struct packed {
        logic           lru;
        way_tag_t [1:0] way;
    } tag_entry_t;

endpackage

/* verilog/icache_ram.sv */
// Simple dual-port RAM, one entry per set, used for the tag entries and both way lines
module icache_ram #(
    parameter int  SET_WIDTH = 6,
    parameter type word_t    = logic [31:0]
) (
    input  logic                 clk,

    // Read port, data valid one cycle after the address
    input  logic [SET_WIDTH-1:0] raddr_i,
    output word_t                rdata_o,

    // Write port
    input  logic                 we_i,
    input  logic [SET_WIDTH-1:0] waddr_i,
    input  word_t                wdata_i
);

    localparam int DEPTH = 2 ** SET_WIDTH;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Old data on a same-address collision
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* verilog/icache_lookup.sv */
// Lookup stage, holds the accepted address and resolves hit, way and word from RAM read data
module icache_lookup #(
    parameter int SET_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,

    input  icache_types_pkg::cpu_req_t             cpu_req_i,
    input  logic                                   accept_i,

    // RAM read data for the accepted set
    input  icache_types_pkg::tag_entry_t           tag_entry_i,
    input  icache_types_pkg::line_t                line0_i,
    input  icache_types_pkg::line_t                line1_i,

    output logic                                   hit_o,
    output logic                                   hit_way_o,
    output logic [icache_cfg_pkg::WORD_WIDTH-1:0]  word_o,
    output logic [icache_cfg_pkg::ADDR_WIDTH-1:0]  lookup_addr_o
);

    localparam int AW  = icache_cfg_pkg::ADDR_WIDTH;
    localparam int BW  = icache_cfg_pkg::BLOCK_WIDTH;
    localparam int LAW = icache_cfg_pkg::LINE_ADDR_WIDTH;
    localparam int WW  = icache_cfg_pkg::WORD_WIDTH;
    localparam int WSW = icache_cfg_pkg::WORD_SEL_WIDTH;

    logic [AW-1:0]           addr_q;
    logic [LAW-1:SET_WIDTH]  req_upper;
    logic [1:0]              way_hit;
    logic [WSW-1:0]          word_sel;
    icache_types_pkg::line_t line_sel;

    // Address stays put until the next accepted request
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (accept_i) begin
            addr_q <= cpu_req_i.addr;
        end
    end

    // The entry was read at this very set, so the set bits of the
    // stored line address always match and need no comparator
    assign req_upper = addr_q[AW-1:BW+SET_WIDTH];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = tag_entry_i.way[w].valid &&
                         (tag_entry_i.way[w].line_addr[LAW-1:SET_WIDTH] == req_upper);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // Word select bits sit right above the byte-in-word bits
    assign word_sel = addr_q[BW-1 -: WSW];
    assign line_sel = way_hit[1] ? line1_i : line0_i;
    assign word_o   = line_sel[word_sel*WW +: WW];

    assign lookup_addr_o = addr_q;

endmodule

/* verilog/icache_ctrl.sv */
// Cache control FSM, runs the reset sweep, hit update, refill, invalidate and all RAM writes
module icache_ctrl #(
    parameter int SET_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,

    input  icache_types_pkg::cpu_req_t             cpu_req_i,
    input  icache_types_pkg::inval_t               inval_i,
    output logic                                   ready_o,
    output logic                                   accept_o,

    // From lookup
    input  logic                                   hit_i,
    input  logic                                   hit_way_i,
    input  logic [icache_cfg_pkg::WORD_WIDTH-1:0]  word_i,
    input  logic [icache_cfg_pkg::ADDR_WIDTH-1:0]  lookup_addr_i,
    input  icache_types_pkg::tag_entry_t           tag_entry_i,

    // Memory side
    input  icache_types_pkg::refill_t              refill_i,
    output icache_types_pkg::refill_req_t          refill_req_o,

    output icache_types_pkg::cpu_resp_t            cpu_resp_o,

    // RAM write ports
    output logic                                   tag_we_o,
    output logic [SET_WIDTH-1:0]                   tag_waddr_o,
    output icache_types_pkg::tag_entry_t           tag_wdata_o,
    output logic [1:0]                             way_we_o,
    output logic [SET_WIDTH-1:0]                   way_waddr_o,
    output icache_types_pkg::line_t                way_wdata_o
);

    localparam int AW  = icache_cfg_pkg::ADDR_WIDTH;
    localparam int BW  = icache_cfg_pkg::BLOCK_WIDTH;
    localparam int WW  = icache_cfg_pkg::WORD_WIDTH;
    localparam int WSW = icache_cfg_pkg::WORD_SEL_WIDTH;

    typedef enum logic [2:0] {
        CLEAR,
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND,
        INVAL
    } state_t;

    state_t                       state;
    logic [SET_WIDTH-1:0]         clr_idx;
    logic [SET_WIDTH-1:0]         inval_set;
    logic [SET_WIDTH-1:0]         lookup_set;
    icache_types_pkg::tag_entry_t saved_entry;
    logic [WW-1:0]                resp_word;
    logic [WSW-1:0]               word_sel;
    logic                         victim;

    assign lookup_set = lookup_addr_i[BW +: SET_WIDTH];
    assign word_sel   = lookup_addr_i[BW-1 -: WSW];
    assign victim     = saved_entry.lru;

    assign ready_o  = (state == IDLE);
    // Invalidate wins over a request in the same cycle
    assign accept_o = ready_o && cpu_req_i.valid && !inval_i.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= CLEAR;
            clr_idx <= '0;
        end else begin
            case (state)
                CLEAR: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == {SET_WIDTH{1'b1}}) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (inval_i.valid) begin
                        state <= INVAL;
                    end else if (cpu_req_i.valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: state <= hit_i ? IDLE : REFILL;
                REFILL: begin
                    // Latency set by memory, no timeout
                    if (refill_i.valid) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                INVAL:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Miss context and response word
    always_ff @(posedge clk) begin
        if (state == IDLE && inval_i.valid) begin
            inval_set <= inval_i.addr[BW +: SET_WIDTH];
        end
        if (state == LOOKUP && !hit_i) begin
            saved_entry <= tag_entry_i;
        end
        if (state == REFILL && refill_i.valid) begin
            resp_word <= refill_i.line[word_sel*WW +: WW];
        end
    end

    // Ack on a hit in the lookup cycle, or the cycle after the refill strobe
    always_comb begin
        cpu_resp_o.ack  = (state == LOOKUP && hit_i) || (state == RESPOND);
        cpu_resp_o.word = (state == RESPOND) ? resp_word : word_i;
    end

    always_comb begin
        refill_req_o.valid     = (state == LOOKUP) && !hit_i;
        refill_req_o.line_addr = lookup_addr_i[AW-1:BW];
    end

    always_comb begin
        tag_we_o    = 1'b0;
        tag_waddr_o = lookup_set;
        tag_wdata_o = tag_entry_i;
        way_we_o    = 2'b00;
        way_waddr_o = lookup_set;
        way_wdata_o = refill_i.line;
        case (state)
            CLEAR: begin
                tag_we_o    = 1'b1;
                tag_waddr_o = clr_idx;
                tag_wdata_o = '0;
            end
            LOOKUP: begin
                // Point LRU at the way not just used
                tag_we_o        = hit_i;
                tag_wdata_o.lru = ~hit_way_i;
            end
            REFILL: begin
                tag_we_o                          = refill_i.valid;
                tag_wdata_o                       = saved_entry;
                tag_wdata_o.way[victim].valid     = 1'b1;
                tag_wdata_o.way[victim].line_addr = lookup_addr_i[AW-1:BW];
                tag_wdata_o.lru                   = ~victim;
                way_we_o[victim]                  = refill_i.valid;
            end
            INVAL: begin
                // Both valid bits and LRU cleared
                tag_we_o    = 1'b1;
                tag_waddr_o = inval_set;
                tag_wdata_o = '0;
            end
            default: begin
            end
        endcase
    end

endmodule

/* verilog/icache_top.sv */
// Two-way instruction cache top, connects tag and way RAMs with the lookup and control stages
module icache_top #(
    parameter int SET_WIDTH = icache_cfg_pkg::DEFAULT_SET_WIDTH
) (
    input  logic                           clk,
    input  logic                           rst,

    input  icache_types_pkg::cpu_req_t     cpu_req_i,
    output logic                           ready_o,
    output icache_types_pkg::cpu_resp_t    cpu_resp_o,

    output icache_types_pkg::refill_req_t  refill_req_o,
    input  icache_types_pkg::refill_t      refill_i,

    input  icache_types_pkg::inval_t       inval_i
);

    localparam int BW = icache_cfg_pkg::BLOCK_WIDTH;

    logic [SET_WIDTH-1:0]                  rd_set;
    icache_types_pkg::tag_entry_t          tag_rdata;
    icache_types_pkg::line_t               line0;
    icache_types_pkg::line_t               line1;

    logic                                  accept;
    logic                                  hit;
    logic                                  hit_way;
    logic [icache_cfg_pkg::WORD_WIDTH-1:0] hit_word;
    logic [icache_cfg_pkg::ADDR_WIDTH-1:0] lookup_addr;

    logic                                  tag_we;
    logic [SET_WIDTH-1:0]                  tag_waddr;
    icache_types_pkg::tag_entry_t          tag_wdata;
    logic [1:0]                            way_we;
    logic [SET_WIDTH-1:0]                  way_waddr;
    icache_types_pkg::line_t               way_wdata;

    // Read every cycle, only the accepted cycle's data is used
    assign rd_set = cpu_req_i.addr[BW +: SET_WIDTH];

    icache_ram #(
        .SET_WIDTH (SET_WIDTH),
        .word_t    (icache_types_pkg::tag_entry_t)
    ) tag_ram (
        .clk     (clk),
        .raddr_i (rd_set),
        .rdata_o (tag_rdata),
        .we_i    (tag_we),
        .waddr_i (tag_waddr),
        .wdata_i (tag_wdata)
    );

    icache_ram #(
        .SET_WIDTH (SET_WIDTH),
        .word_t    (icache_types_pkg::line_t)
    ) way0_ram (
        .clk     (clk),
        .raddr_i (rd_set),
        .rdata_o (line0),
        .we_i    (way_we[0]),
        .waddr_i (way_waddr),
        .wdata_i (way_wdata)
    );

    icache_ram #(
        .SET_WIDTH (SET_WIDTH),
        .word_t    (icache_types_pkg::line_t)
    ) way1_ram (
        .clk     (clk),
        .raddr_i (rd_set),
        .rdata_o (line1),
        .we_i    (way_we[1]),
        .waddr_i (way_waddr),
        .wdata_i (way_wdata)
    );

    icache_lookup #(
        .SET_WIDTH (SET_WIDTH)
    ) i_lookup (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_i     (cpu_req_i),
        .accept_i      (accept),
        .tag_entry_i   (tag_rdata),
        .line0_i       (line0),
        .line1_i       (line1),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .word_o        (hit_word),
        .lookup_addr_o (lookup_addr)
    );

    icache_ctrl #(
        .SET_WIDTH (SET_WIDTH)
    ) i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_i     (cpu_req_i),
        .inval_i       (inval_i),
        .ready_o       (ready_o),
        .accept_o      (accept),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .word_i        (hit_word),
        .lookup_addr_i (lookup_addr),
        .tag_entry_i   (tag_rdata),
        .refill_i      (refill_i),
        .refill_req_o  (refill_req_o),
        .cpu_resp_o    (cpu_resp_o),
        .tag_we_o      (tag_we),
        .tag_waddr_o   (tag_waddr),
        .tag_wdata_o   (tag_wdata),
        .way_we_o      (way_we),
        .way_waddr_o   (way_waddr),
        .way_wdata_o   (way_wdata)
    );

endmodule

/* dv/icache_asserts.sv */
// Protocol assertions for the cache control FSM, attached to icache_ctrl with bind
module icache_asserts (
    input logic clk,
    input logic rst,
    input logic ready_i,
    input logic accept_i,
    input logic ack_i,
    input logic refill_req_i,
    input logic refill_i
);

    // Read by the testbench at the end of the run
    int   fail_count = 0;
    logic refill_pending;

    // Set by the request strobe, cleared by the refill strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_pending <= 1'b0;
        end else if (refill_req_i) begin
            refill_pending <= 1'b1;
        end else if (refill_i) begin
            refill_pending <= 1'b0;
        end
    end

    ack_refill_apart: assert property (@(posedge clk) disable iff (rst)
        !(ack_i && refill_req_i))
    else begin
        $error("ack and refill request in the same cycle");
        fail_count++;
    end

    no_ready_in_refill: assert property (@(posedge clk) disable iff (rst)
        refill_pending |-> !ready_i)
    else begin
        $error("ready_o high while a refill is outstanding");
        fail_count++;
    end

    // Hit ack comes from the lookup cycle, miss ack from the refill strobe
    ack_has_source: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> ($past(accept_i) || $past(refill_i)))
    else begin
        $error("ack without an accepted request or refill one cycle before");
        fail_count++;
    end

endmodule

bind icache_ctrl icache_asserts i_asserts (
    .clk          (clk),
    .rst          (rst),
    .ready_i      (ready_o),
    .accept_i     (accept_o),
    .ack_i        (cpu_resp_o.ack),
    .refill_req_i (refill_req_o.valid),
    .refill_i     (refill_i.valid)
);

/* dv/icache_tb.sv */
// Testbench for the two-way instruction cache, directed and random fetches against a reference model
module icache_tb;

    localparam int SET_WIDTH = 4;
    localparam int SETS      = 2 ** SET_WIDTH;
    localparam int BW        = icache_cfg_pkg::BLOCK_WIDTH;
    localparam int LAW       = icache_cfg_pkg::LINE_ADDR_WIDTH;
    localparam int WW        = icache_cfg_pkg::WORD_WIDTH;
    localparam int RAND_REQS = 300;
    // Directed fetches plus random fetches and their invalidates
    localparam int MAX_OPS   = 40 + 2 * RAND_REQS;
    // Accept, lookup, up to 10 memory cycles, respond, ready
    localparam int MISS_CYCLES = 16;
    localparam int CYCLE_LIMIT = MAX_OPS * MISS_CYCLES + SETS + 100;
    localparam logic [31:0] MEM_KEY   = 32'h5a3c_96e1;
    localparam logic [31:0] RAND_BASE = 32'h0008_0000;

    typedef struct packed {
        logic [31:0] addr;
        logic        hit;
        logic [31:0] word;
        int          acc_cyc;
    } expect_t;

    logic                            clk;
    logic                            rst;
    icache_types_pkg::cpu_req_t      cpu_req;
    logic                            ready;
    icache_types_pkg::cpu_resp_t     cpu_resp;
    icache_types_pkg::refill_req_t   refill_req;
    icache_types_pkg::refill_t       refill;
    icache_types_pkg::inval_t        inval;

    integer seed = 93;
    int     cyc = 0;
    int     refill_cyc = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     failed_tests = 0;
    int     req_count = 0;
    int     ack_count = 0;

    expect_t exp_q [$];

    // Reference state per set
    logic           ref_valid [SETS][2];
    logic [LAW-1:0] ref_tag   [SETS][2];
    logic           ref_lru   [SETS];

    icache_top #(
        .SET_WIDTH (SET_WIDTH)
    ) i_icache_top (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .ready_o      (ready),
        .cpu_resp_o   (cpu_resp),
        .refill_req_o (refill_req),
        .refill_i     (refill),
        .inval_i      (inval)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Memory word is its word address scrambled by a constant
    function automatic logic [31:0] mem_word(input logic [29:0] word_addr);
        return {2'b00, word_addr} ^ MEM_KEY;
    endfunction

    function automatic icache_types_pkg::line_t make_line(input logic [LAW-1:0] line_addr);
        icache_types_pkg::line_t line;
        for (int i = 0; i < 8; i++) begin
            line[i*WW +: WW] = mem_word({line_addr, 3'(i)});
        end
        return line;
    endfunction

    function automatic void ref_clear();
        for (int s = 0; s < SETS; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
            ref_tag[s][0]   = '0;
            ref_tag[s][1]   = '0;
            ref_lru[s]      = 1'b0;
        end
    endfunction

    function automatic void ref_inval(input logic [31:0] addr);
        logic [SET_WIDTH-1:0] idx;
        idx = addr[BW +: SET_WIDTH];
        ref_valid[idx][0] = 1'b0;
        ref_valid[idx][1] = 1'b0;
        ref_lru[idx]      = 1'b0;
    endfunction

    // Predicts hit and word, and updates tags and LRU like the cache should
    function automatic void predict(input logic [31:0] addr, output logic hit,
                                    output logic [31:0] word);
        logic [LAW-1:0]       line_addr;
        logic [SET_WIDTH-1:0] idx;
        logic                 way;
        line_addr = addr[31:BW];
        idx       = addr[BW +: SET_WIDTH];
        hit       = 1'b0;
        way       = ref_lru[idx];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == line_addr) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        // Miss fills the LRU way
        if (!hit) begin
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = line_addr;
        end
        ref_lru[idx] = ~way;
        word         = mem_word(addr[31:2]);
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready();
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    task automatic fetch(input logic [31:0] addr, output logic dut_hit);
        expect_t     e;
        logic        exp_hit;
        logic [31:0] word;
        wait_ready();
        predict(addr, exp_hit, word);
        e.addr    = addr;
        e.hit     = exp_hit;
        e.word    = word;
        e.acc_cyc = cyc + 1;
        exp_q.push_back(e);
        cpu_req.valid = 1'b1;
        cpu_req.addr  = addr;
        req_count++;
        @(negedge clk);
        cpu_req = '0;
        // Lookup cycle, a hit acks here and a miss asks for a refill
        dut_hit = cpu_resp.ack;
        wait_ready();
    endtask

    // Fetch and compare the cache's hit or miss with the intended one
    task automatic fetch_expect(input logic [31:0] addr, input logic want_hit, input string what);
        logic hit;
        fetch(addr, hit);
        check(what, 64'(hit), 64'(want_hit));
    endtask

    // Ready drops for exactly one cycle
    task automatic invalidate(input logic [31:0] addr);
        wait_ready();
        ref_inval(addr);
        inval.valid = 1'b1;
        inval.addr  = addr;
        @(negedge clk);
        inval = '0;
        check("ready in invalidate cycle", 64'(ready), 64'(0));
        @(negedge clk);
        check("ready after invalidate", 64'(ready), 64'(1));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - errs_before);
        end
    endtask

    // Memory model, answers 3 to 10 cycles after the request
    initial begin : memory_model
        int             lat;
        logic [LAW-1:0] line_addr;
        refill = '0;
        forever begin
            @(negedge clk);
            if (!rst && refill_req.valid) begin
                line_addr = refill_req.line_addr;
                lat       = 3 + ({$random(seed)} % 8);
                repeat (lat) @(negedge clk);
                refill.valid = 1'b1;
                refill.line  = make_line(line_addr);
                refill_cyc   = cyc + 1;
                @(negedge clk);
                refill = '0;
            end
        end
    end

    // Compares every refill request and ack with the oldest expected fetch
    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            if (!rst && refill_req.valid) begin
                if (exp_q.size() == 0 || exp_q[0].hit) begin
                    $display("Error at time %0t: refill request for line %0h was not expected",
                             $time, refill_req.line_addr);
                    errors++;
                end else begin
                    check("refill line address", 64'(refill_req.line_addr),
                          64'(exp_q[0].addr[31:BW]));
                    check("refill request cycle", 64'(cyc), 64'(exp_q[0].acc_cyc));
                end
            end
            if (!rst && cpu_resp.ack) begin
                if (exp_q.size() == 0) begin
                    $display("Error at time %0t: ack came with no fetch pending", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("ack cycle", 64'(cyc), 64'(e.hit ? e.acc_cyc : refill_cyc));
                    check("fetched word", 64'(cpu_resp.word), 64'(e.word));
                    ack_count++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cyc >= CYCLE_LIMIT);
        $display("Timeout: run still busy after %0d cycles, a response never came", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        logic [31:0] addr;
        int          errs;
        int          sweep;
        int          tag_pick;
        int          set_pick;
        int          word_pick;
        logic        hit;
        rst     = 1'b1;
        cpu_req = '0;
        inval   = '0;
        ref_clear();
        repeat (2) @(negedge clk);

        // Sweep clears all sets, then every line is cold
        errs = errors;
        check("ack during reset", 64'(cpu_resp.ack), 64'(0));
        check("refill request during reset", 64'(refill_req.valid), 64'(0));
        check("ready during reset", 64'(ready), 64'(0));
        rst   = 1'b0;
        sweep = 0;
        while (!ready) begin
            @(negedge clk);
            sweep++;
        end
        check("reset sweep cycles", 64'(sweep), 64'(SETS));
        fetch_expect(32'h0000_0104, 1'b0, "first fetch hit");
        finish_test("reset sweep and first miss", errs);

        errs = errors;
        fetch_expect(32'h0000_011c, 1'b1, "same line hit");
        fetch_expect(32'h0000_0104, 1'b1, "refetch hit");
        finish_test("hit in refilled line", errs);

        // Three lines in set 5
        errs   = errors;
        a_addr = 32'h0001_00a4;
        b_addr = 32'h0002_00a8;
        c_addr = 32'h0003_00ac;
        fetch_expect(a_addr, 1'b0, "line A cold");
        fetch_expect(b_addr, 1'b0, "line B cold");
        fetch_expect(a_addr, 1'b1, "line A again");
        fetch_expect(c_addr, 1'b0, "line C evicts B");
        fetch_expect(a_addr, 1'b1, "line A kept");
        fetch_expect(b_addr, 1'b0, "line B evicted");
        finish_test("LRU replacement", errs);

        errs = errors;
        fetch_expect(32'h0004_0158, 1'b0, "fresh line word 6");
        fetch_expect(32'h0004_0140, 1'b1, "fresh line word 0");
        finish_test("miss response timing and word", errs);

        errs = errors;
        invalidate(a_addr);
        fetch_expect(32'h0000_0110, 1'b1, "other set after invalidate");
        fetch_expect(a_addr, 1'b0, "line A after invalidate");
        fetch_expect(b_addr, 1'b0, "line B after invalidate");
        fetch_expect(a_addr, 1'b1, "line A refilled");
        finish_test("set invalidate", errs);

        // Four lines per set compete for two ways
        errs = errors;
        for (int i = 0; i < RAND_REQS; i++) begin
            tag_pick  = {$random(seed)} % 4;
            set_pick  = {$random(seed)} % SETS;
            word_pick = {$random(seed)} % 8;
            if ({$random(seed)} % 16 == 0) begin
                invalidate(RAND_BASE | 32'(set_pick << BW));
            end
            addr = RAND_BASE | 32'(tag_pick << 12) | 32'(set_pick << BW) | 32'(word_pick << 2);
            fetch(addr, hit);
        end
        finish_test("random fetch mix", errs);

        errs = errors;
        repeat (4) @(negedge clk);
        check("fetches still pending", 64'(exp_q.size()), 64'(0));
        check("acks received", 64'(ack_count), 64'(req_count));
        check("assertion failures", 64'(i_icache_top.i_ctrl.i_asserts.fail_count), 64'(0));
        finish_test("drain and totals", errs);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/icache_cfg_pkg.sv
verilog/icache_types_pkg.sv
verilog/icache_ram.sv
verilog/icache_lookup.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_asserts.sv
dv/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module icache_tb -f project.f -o icache_sim \
    && ./obj_dir/icache_sim +verilator+error+limit+100 | tee sim.log \
    || { echo "build or simulation step failed"; exit 1; }
grep -q "^RESULT: PASS$" sim.log \
    && echo "log check ok" \
    || { echo "pass line missing from sim.log"; exit 1; }
